// File: Makefile
# Verilator build and run for the motor register core testbench
# make test    build and run the simulation
# make clean   remove build output
# make help    list targets and variables

VERILATOR ?= verilator
TOP       ?= tb_motor_reg
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then exit 0; else exit 1; fi

clean:
	rm -rf $(BUILD_DIR)

// File: common/motor_pkg.sv
// ------------------------------
// shared types and constants for the motor register core
// currents are offset binary, 16'h8000 is zero current
// amplifier-enable mask is 4 bits wide, so at most 4 channels
// ------------------------------

package motor_pkg;

    // ------------------------------
    // vector types
    // ------------------------------
    typedef logic [15:0] reg_addr_t;    // host register address
    typedef logic [31:0] reg_data_t;    // host register data
    typedef logic [3:0]  chan_t;        // addr[7:4]
    typedef logic [3:0]  offset_t;      // addr[3:0]
    typedef logic [3:0]  space_t;       // addr[15:12]
    typedef logic [15:0] cur_t;         // offset binary current

    // ------------------------------
    // address map
    // ------------------------------
    localparam space_t  ADDR_MAIN        = 4'h0;   // only space decoded here
    localparam offset_t OFF_ADC_DATA     = 4'd0;   // current feedback
    localparam offset_t OFF_DAC_CTRL     = 4'd1;   // commanded current
    localparam offset_t OFF_MOTOR_STATUS = 4'd12;
    localparam offset_t OFF_BOARD_STATUS = 4'd0;   // channel 0 only

    // status word layout
    localparam int MOTOR_AMP_EN_BIT = 28;   // amp enabled flag in motor status
    localparam int BOARD_ID_LSB     = 24;   // board id field, 27:24
    localparam int ENA_PWR_BIT      = 4;    // power enable in board status write

    // reset value and trip allowance
    localparam cur_t CUR_MIDSCALE  = 16'h8000;
    localparam cur_t SAFETY_MARGIN = 16'd256;

    // ------------------------------
    // bus structs
    // ------------------------------
    // host write bus, 50 bits
    typedef struct packed {
        logic      wen;        // write strobe
        logic      blk_wen;    // part of a block write
        reg_addr_t waddr;
        reg_data_t wdata;
    } reg_wr_t;

    // decoded command write for one channel
    typedef struct packed {
        logic  strobe;
        chan_t chan;       // always 1..NUM_CHAN when strobe is set
        cur_t  value;
        logic  blk;        // request a dac update
    } cmd_wr_t;

    // decoded board status write
    typedef struct packed {
        logic       strobe;
        logic       pwr_en;    // clears every channel
        logic [3:0] amp_en;    // bit n-1 clears channel n
    } enable_wr_t;

    // address field helpers
    function automatic space_t addr_space(reg_addr_t addr);
        return addr[15:12];
    endfunction

    function automatic chan_t addr_chan(reg_addr_t addr);
        return addr[7:4];
    endfunction

    function automatic offset_t addr_offset(reg_addr_t addr);
        return addr[3:0];
    endfunction

endpackage

// File: cur_cmd/cur_cmd_bank.sv
// ------------------------------
// commanded current per channel plus deferred dac request
// cmd_wr.chan must already be in range 1..NUM_CHAN
// request waits as long as dac_busy stays high
// ------------------------------

`timescale 1ns/1ps

module cur_cmd_bank #(
    parameter int NUM_CHAN = 4
) (
    input  logic                         clk_125MHz,
    input  logic                         arst_n,
    input  motor_pkg::cmd_wr_t           cmd_wr,
    input  logic                         dac_busy,
    output motor_pkg::cur_t [NUM_CHAN:1] cur_cmd,
    output logic                         dac_update
);
    import motor_pkg::*;

    cur_t [NUM_CHAN:1] cmd_q;     // stored commands
    logic              req_pending;
    logic              req_release;

    // ------------------------------
    // command registers
    // ------------------------------
    always_ff @(posedge clk_125MHz or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q <= {NUM_CHAN{CUR_MIDSCALE}};   // zero current
        end else if (cmd_wr.strobe) begin
            cmd_q[cmd_wr.chan] <= cmd_wr.value;
        end
    end

    // forward the registered decode so a write shows up
    // right after the bus edge that sampled it
    for (genvar ch = 1; ch <= NUM_CHAN; ch++) begin : g_fwd
        assign cur_cmd[ch] = (cmd_wr.strobe && cmd_wr.chan == chan_t'(ch)) ?
                             cmd_wr.value : cmd_q[ch];
    end

    // ------------------------------
    // dac update request
    // ------------------------------
    assign req_release = req_pending & ~dac_busy;   // dac free, hand it over

    always_ff @(posedge clk_125MHz or negedge arst_n) begin
        if (!arst_n) begin
            req_pending <= 1'b0;
            dac_update  <= 1'b0;
        end else begin
            dac_update <= req_release;     // single pulse per release
            if (cmd_wr.strobe && cmd_wr.blk) begin
                req_pending <= 1'b1;       // new block data wins over release
            end else if (req_release) begin
                req_pending <= 1'b0;
            end
            // plain writes leave the request alone
        end
    end

endmodule

// File: hdl/motor_reg_top.sv
// ------------------------------
// motor channel register core, host bus only
// adc controller and dac serializer sit outside
// channels are numbered 1..NUM_CHAN, NUM_CHAN at most 4
// ------------------------------

`timescale 1ns/1ps

module motor_reg_top #(
    parameter int NUM_CHAN     = 4,
    parameter int SAFETY_COUNT = 3
) (
    input  logic                               clk_125MHz,
    input  logic                               arst_n,
    // host register bus
    input  motor_pkg::reg_wr_t                 reg_wr,
    input  motor_pkg::reg_addr_t               reg_raddr,
    output motor_pkg::reg_data_t               reg_rdata,
    // adc side
    input  motor_pkg::cur_t [NUM_CHAN:1]       cur_fb,
    input  logic                               cur_fb_valid,   // 1-cycle strobe
    input  logic [3:0]                         board_id,
    // dac side
    input  logic                               dac_busy,
    output logic                               dac_update,     // 1-cycle pulse
    output motor_pkg::cur_t [NUM_CHAN:1]       cur_cmd,
    output logic [NUM_CHAN:1]                  amp_disable
);
    import motor_pkg::*;

    cmd_wr_t    cmd_wr;       // registered command write
    enable_wr_t enable_wr;    // registered board status write

    // ------------------------------
    // decode
    // ------------------------------
    reg_decode #(.NUM_CHAN(NUM_CHAN)) u_decode (
        .clk_125MHz (clk_125MHz),
        .arst_n     (arst_n),
        .reg_wr     (reg_wr),
        .cmd_wr     (cmd_wr),
        .enable_wr  (enable_wr)
    );

    // ------------------------------
    // execute: commands and safety
    // ------------------------------
    cur_cmd_bank #(.NUM_CHAN(NUM_CHAN)) u_cmd_bank (
        .clk_125MHz (clk_125MHz),
        .arst_n     (arst_n),
        .cmd_wr     (cmd_wr),
        .dac_busy   (dac_busy),
        .cur_cmd    (cur_cmd),      // also feeds safety and read mux
        .dac_update (dac_update)
    );

    for (genvar ch = 1; ch <= NUM_CHAN; ch++) begin : g_safety
        safety_check #(.SAFETY_COUNT(SAFETY_COUNT)) u_safety (
            .clk_125MHz   (clk_125MHz),
            .arst_n       (arst_n),
            .cur_fb       (cur_fb[ch]),
            .cur_fb_valid (cur_fb_valid),
            .cur_cmd      (cur_cmd[ch]),
            // power enable clears all, mask bit clears this one
            .clear        (enable_wr.strobe & (enable_wr.pwr_en | enable_wr.amp_en[ch-1])),
            .amp_disable  (amp_disable[ch])
        );
    end

    // ------------------------------
    // result: read data
    // ------------------------------
    read_mux #(.NUM_CHAN(NUM_CHAN)) u_read_mux (
        .reg_raddr   (reg_raddr),
        .cur_fb      (cur_fb),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable),
        .board_id    (board_id),
        .reg_rdata   (reg_rdata)
    );

endmodule

// File: hdl/read_mux.sv
// ------------------------------
// combinational read data select
// unknown spaces, offsets and channels read zero
// ------------------------------

`timescale 1ns/1ps

module read_mux #(
    parameter int NUM_CHAN = 4
) (
    input  motor_pkg::reg_addr_t         reg_raddr,
    input  motor_pkg::cur_t [NUM_CHAN:1] cur_fb,
    input  motor_pkg::cur_t [NUM_CHAN:1] cur_cmd,
    input  logic [NUM_CHAN:1]            amp_disable,
    input  logic [3:0]                   board_id,
    output motor_pkg::reg_data_t         reg_rdata
);
    import motor_pkg::*;

    space_t    rd_space;
    chan_t     rd_chan;
    offset_t   rd_offset;
    logic      chan_ok;       // motor channel in 1..NUM_CHAN
    reg_data_t board_word;

    assign rd_space  = addr_space(reg_raddr);
    assign rd_chan   = addr_chan(reg_raddr);
    assign rd_offset = addr_offset(reg_raddr);
    assign chan_ok   = (rd_chan != 4'd0) && (int'(rd_chan) <= NUM_CHAN);

    // board status: id up top, latched disables in the low bits
    always_comb begin
        board_word = '0;
        board_word[BOARD_ID_LSB +: 4] = board_id;
        board_word[NUM_CHAN-1:0]      = amp_disable;
    end

    always_comb begin
        reg_rdata = '0;
        if (rd_space == ADDR_MAIN) begin
            if (rd_chan == 4'd0) begin
                if (rd_offset == OFF_BOARD_STATUS) begin
                    reg_rdata = board_word;
                end
            end else if (chan_ok) begin
                case (rd_offset)
                    OFF_ADC_DATA:     reg_rdata[15:0] = cur_fb[rd_chan];
                    OFF_DAC_CTRL:     reg_rdata[15:0] = cur_cmd[rd_chan];
                    OFF_MOTOR_STATUS: begin
                        reg_rdata[MOTOR_AMP_EN_BIT] = ~amp_disable[rd_chan];  // amp enabled
                        reg_rdata[15:0]             = cur_cmd[rd_chan];
                    end
                    default:          reg_rdata = '0;
                endcase
            end
        end
    end

endmodule

// File: hdl/reg_decode.sv
// ------------------------------
// host write decode, one register stage
// only space ADDR_MAIN is served, the rest is dropped
// ------------------------------

`timescale 1ns/1ps

module reg_decode #(
    parameter int NUM_CHAN = 4
) (
    input  logic                  clk_125MHz,
    input  logic                  arst_n,
    input  motor_pkg::reg_wr_t    reg_wr,
    output motor_pkg::cmd_wr_t    cmd_wr,
    output motor_pkg::enable_wr_t enable_wr
);
    import motor_pkg::*;

    space_t  wr_space;
    chan_t   wr_chan;
    offset_t wr_offset;
    logic    cmd_hit;     // dac command on a real motor channel
    logic    ena_hit;     // board status on channel 0

    // registered decode
    logic       cmd_stb_q;
    logic       ena_stb_q;
    chan_t      cmd_chan_q;
    cur_t       cmd_value_q;
    logic       cmd_blk_q;
    logic       ena_pwr_q;
    logic [3:0] ena_mask_q;

    assign wr_space  = addr_space(reg_wr.waddr);
    assign wr_chan   = addr_chan(reg_wr.waddr);
    assign wr_offset = addr_offset(reg_wr.waddr);

    assign cmd_hit = reg_wr.wen && (wr_space == ADDR_MAIN) && (wr_offset == OFF_DAC_CTRL)
                     && (wr_chan != 4'd0) && (int'(wr_chan) <= NUM_CHAN);
    assign ena_hit = reg_wr.wen && (wr_space == ADDR_MAIN) && (wr_chan == 4'd0)
                     && (wr_offset == OFF_BOARD_STATUS);

    // strobes, reset to idle
    always_ff @(posedge clk_125MHz or negedge arst_n) begin
        if (!arst_n) begin
            cmd_stb_q <= 1'b0;
            ena_stb_q <= 1'b0;
        end else begin
            cmd_stb_q <= cmd_hit;
            ena_stb_q <= ena_hit;
        end
    end

    // write payload, sampled every cycle
    always_ff @(posedge clk_125MHz) begin
        cmd_chan_q  <= wr_chan;
        cmd_value_q <= reg_wr.wdata[15:0];
        cmd_blk_q   <= reg_wr.blk_wen;
        ena_pwr_q   <= reg_wr.wdata[ENA_PWR_BIT];
        ena_mask_q  <= reg_wr.wdata[3:0];       // one bit per channel
    end

    assign cmd_wr    = '{strobe: cmd_stb_q, chan: cmd_chan_q, value: cmd_value_q,
                         blk: cmd_blk_q};
    assign enable_wr = '{strobe: ena_stb_q, pwr_en: ena_pwr_q, amp_en: ena_mask_q};

endmodule

// File: safety/safety_check.sv
// ------------------------------
// overcurrent check for one channel
// trips after SAFETY_COUNT consecutive bad strobes, SAFETY_COUNT >= 1
// limit is 2*|cmd| + SAFETY_MARGIN around midscale
// ------------------------------

`timescale 1ns/1ps

module safety_check #(
    parameter int SAFETY_COUNT = 3
) (
    input  logic            clk_125MHz,
    input  logic            arst_n,
    input  motor_pkg::cur_t cur_fb,
    input  logic            cur_fb_valid,
    input  motor_pkg::cur_t cur_cmd,
    input  logic            clear,          // from board status write
    output logic            amp_disable
);
    import motor_pkg::*;

    localparam int CNT_W = $clog2(SAFETY_COUNT + 1);

    typedef logic [16:0] wide_t;   // one spare bit for 2*|cmd| + margin

    cur_t             fb_mag;      // |fb - midscale|
    cur_t             cmd_mag;     // |cmd - midscale|
    wide_t            limit;
    logic             over;
    logic [CNT_W-1:0] run_cnt;     // consecutive over-limit strobes
    logic             disable_q;

    // ------------------------------
    // compare
    // ------------------------------
    always_comb begin
        if (cur_fb >= CUR_MIDSCALE) begin
            fb_mag = cur_fb - CUR_MIDSCALE;
        end else begin
            fb_mag = CUR_MIDSCALE - cur_fb;
        end
        if (cur_cmd >= CUR_MIDSCALE) begin
            cmd_mag = cur_cmd - CUR_MIDSCALE;
        end else begin
            cmd_mag = CUR_MIDSCALE - cur_cmd;   // max 16'h8000
        end
        limit = {cmd_mag, 1'b0} + {1'b0, SAFETY_MARGIN};
        over  = {1'b0, fb_mag} > limit;
    end

    // ------------------------------
    // run counter and latch
    // ------------------------------
    always_ff @(posedge clk_125MHz or negedge arst_n) begin
        if (!arst_n) begin
            run_cnt   <= '0;
            disable_q <= 1'b0;
        end else if (clear) begin
            run_cnt   <= '0;    // clear also restarts the run
            disable_q <= 1'b0;
        end else if (cur_fb_valid) begin
            if (over) begin
                if (run_cnt != CNT_W'(SAFETY_COUNT)) begin
                    run_cnt <= run_cnt + 1'b1;   // saturate
                end
                if (run_cnt >= CNT_W'(SAFETY_COUNT - 1)) begin
                    disable_q <= 1'b1;           // this strobe completes the run
                end
            end else begin
                run_cnt <= '0;  // good sample breaks the run
            end
        end
    end

    // clear takes effect with the decoded write, same as the command path
    assign amp_disable = disable_q & ~clear;

endmodule

// File: test/tb_motor_reg.sv
// ------------------------------
// testbench for motor_reg_top, 4 channels, trip after 3 strobes
// reference model follows the register map rules
// stops at the first failing check
// ------------------------------

`timescale 1ns/1ps

module tb_motor_reg;
    import motor_pkg::*;

    localparam int NUM_CHAN     = 4;
    localparam int SAFETY_COUNT = 3;
    localparam int WAIT_LIMIT   = 50;   // cycles per wait loop

    logic              clk_125MHz;
    logic              arst_n;
    reg_wr_t           reg_wr;
    reg_addr_t         reg_raddr;
    reg_data_t         reg_rdata;
    cur_t [NUM_CHAN:1] cur_fb;
    logic              cur_fb_valid;
    logic [3:0]        board_id;
    logic              dac_busy;
    logic              dac_update;
    cur_t [NUM_CHAN:1] cur_cmd;
    logic [NUM_CHAN:1] amp_disable;

    // reference model
    cur_t              cmd_model [1:NUM_CHAN];
    int                run_model [1:NUM_CHAN];   // consecutive over-limit strobes
    logic [NUM_CHAN:1] dis_model;
    int                update_count = 0;         // dac_update pulses seen
    logic [15:0]       lfsr_q = 16'd44776;

    motor_reg_top #(.NUM_CHAN(NUM_CHAN), .SAFETY_COUNT(SAFETY_COUNT)) uut (
        .clk_125MHz   (clk_125MHz),
        .arst_n       (arst_n),
        .reg_wr       (reg_wr),
        .reg_raddr    (reg_raddr),
        .reg_rdata    (reg_rdata),
        .cur_fb       (cur_fb),
        .cur_fb_valid (cur_fb_valid),
        .board_id     (board_id),
        .dac_busy     (dac_busy),
        .dac_update   (dac_update),
        .cur_cmd      (cur_cmd),
        .amp_disable  (amp_disable)
    );

    initial begin
        clk_125MHz = 1'b0;
        forever #4 clk_125MHz = ~clk_125MHz;   // 8 ns period
    end

    always @(negedge clk_125MHz) begin
        if (arst_n && dac_update) begin
            update_count <= update_count + 1;
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic stop_run(string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] expected);
        stop_run($sformatf("mismatch at %0t: %s, got %h expected %h",
                           $time, what, got, expected));
    endtask

    // dac_update never lasts two cycles
    assert property (@(posedge clk_125MHz) disable iff (!arst_n)
                     !(dac_update && $past(dac_update)))
        else report_mismatch("dac_update wider than one cycle", 32'(dac_update), 32'd0);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);     // one step per bit
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic reg_addr_t make_addr(space_t sp, chan_t ch, offset_t off);
        return {sp, 4'h0, ch, off};
    endfunction

    // |fb - mid| > 2*|cmd - mid| + margin
    function automatic bit over_limit(cur_t fb, cur_t cmd);
        int fb_dist;
        int cmd_dist;
        fb_dist  = (int'(fb) >= 32768) ? int'(fb) - 32768 : 32768 - int'(fb);
        cmd_dist = (int'(cmd) >= 32768) ? int'(cmd) - 32768 : 32768 - int'(cmd);
        return fb_dist > 2 * cmd_dist + int'(SAFETY_MARGIN);
    endfunction

    function automatic reg_data_t motor_status_word(int ch);
        return {3'b000, ~dis_model[ch], 12'h000, cmd_model[ch]};   // bit 28 amp enabled
    endfunction

    function automatic reg_data_t board_status_word();
        return {4'h0, board_id, 20'h00000, dis_model};
    endfunction

    // outputs against model, called at a falling edge
    task automatic check_outputs(string what);
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            assert (cur_cmd[ch] == cmd_model[ch])
                else report_mismatch($sformatf("%s, cur_cmd[%0d]", what, ch),
                                     32'(cur_cmd[ch]), 32'(cmd_model[ch]));
        end
        assert (amp_disable == dis_model)
            else report_mismatch({what, ", amp_disable"}, 32'(amp_disable), 32'(dis_model));
    endtask

    task automatic bus_write(reg_addr_t addr, reg_data_t data, logic blk);
        @(posedge clk_125MHz);
        reg_wr <= '{wen: 1'b1, blk_wen: blk, waddr: addr, wdata: data};
        @(posedge clk_125MHz);                  // write sampled here
        reg_wr <= '{wen: 1'b0, blk_wen: 1'b0, waddr: '0, wdata: '0};
    endtask

    task automatic read_check(reg_addr_t addr, reg_data_t expected, string what);
        @(posedge clk_125MHz);
        reg_raddr <= addr;
        @(negedge clk_125MHz);                  // combinational read settled
        assert (reg_rdata == expected)
            else report_mismatch(what, reg_rdata, expected);
    endtask

    task automatic write_command(int ch, cur_t value, logic blk);
        bus_write(make_addr(ADDR_MAIN, chan_t'(ch), OFF_DAC_CTRL), {16'h0, value}, blk);
        cmd_model[ch] = value;
        @(negedge clk_125MHz);
        check_outputs("after command write");   // visible right after the sampling edge
    endtask

    task automatic enable_write(logic pwr, logic [3:0] mask);
        bus_write(make_addr(ADDR_MAIN, 4'd0, OFF_BOARD_STATUS), {27'h0, pwr, mask}, 1'b0);
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            if (pwr || mask[ch-1]) begin
                dis_model[ch] = 1'b0;
                run_model[ch] = 0;
            end
        end
        @(negedge clk_125MHz);
        check_outputs("after enable write");
    endtask

    task automatic feedback_strobe(cur_t [NUM_CHAN:1] fb);
        @(posedge clk_125MHz);
        cur_fb       <= fb;
        cur_fb_valid <= 1'b1;
        @(posedge clk_125MHz);                  // strobe sampled here
        cur_fb_valid <= 1'b0;
        for (int ch = 1; ch <= NUM_CHAN; ch++) begin
            if (over_limit(fb[ch], cmd_model[ch])) begin
                run_model[ch]++;
                if (run_model[ch] >= SAFETY_COUNT) begin
                    dis_model[ch] = 1'b1;
                end
            end else begin
                run_model[ch] = 0;              // run broken
            end
        end
        @(negedge clk_125MHz);
        check_outputs("after feedback strobe");
    endtask

    task automatic wait_updates(int target);
        int n;
        n = 0;
        while (update_count < target) begin
            @(negedge clk_125MHz);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_run("timeout: no dac_update pulse after dac_busy fell");
            end
        end
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        int                ch;
        cur_t              value;
        cur_t [NUM_CHAN:1] fb_ok;
        cur_t [NUM_CHAN:1] fb_bad;

        arst_n       = 1'b0;
        reg_wr       = '0;
        reg_raddr    = '0;
        cur_fb       = {NUM_CHAN{CUR_MIDSCALE}};
        cur_fb_valid = 1'b0;
        board_id     = 4'(rand_bits(4));
        dac_busy     = 1'b0;
        dis_model    = '0;
        for (int i = 1; i <= NUM_CHAN; i++) begin
            cmd_model[i] = CUR_MIDSCALE;
            run_model[i] = 0;
        end
        repeat (4) @(posedge clk_125MHz);
        arst_n <= 1'b1;

        // reset values
        @(negedge clk_125MHz);
        check_outputs("after reset");
        for (int i = 1; i <= NUM_CHAN; i++) begin
            read_check(make_addr(ADDR_MAIN, chan_t'(i), OFF_DAC_CTRL), {16'h0, CUR_MIDSCALE},
                       "reset command");
        end

        // random command writes and readback
        for (int i = 0; i < 8; i++) begin
            ch    = 1 + int'(rand_bits(2));
            value = cur_t'(rand_bits(16));
            write_command(ch, value, 1'b0);
            read_check(make_addr(ADDR_MAIN, chan_t'(ch), OFF_DAC_CTRL), {16'h0, value},
                       "command readback");
        end

        // writes that must be dropped
        bus_write(make_addr(ADDR_MAIN, 4'd0, OFF_DAC_CTRL), 32'h1234, 1'b0);   // channel 0
        bus_write(make_addr(ADDR_MAIN, 4'd5, OFF_DAC_CTRL), 32'h1234, 1'b0);   // beyond range
        bus_write(make_addr(ADDR_MAIN, 4'd2, 4'd2), 32'h1234, 1'b0);           // bad offset
        bus_write(make_addr(4'h1, 4'd1, OFF_DAC_CTRL), 32'h1234, 1'b0);        // other space
        @(negedge clk_125MHz);
        check_outputs("after dropped writes");
        for (int i = 1; i <= NUM_CHAN; i++) begin
            read_check(make_addr(ADDR_MAIN, chan_t'(i), OFF_DAC_CTRL), {16'h0, cmd_model[i]},
                       "command after dropped writes");
        end
        read_check(make_addr(4'h1, 4'd1, OFF_DAC_CTRL), '0, "read of space 1");
        read_check(make_addr(4'h2, 4'd0, OFF_BOARD_STATUS), '0, "read of space 2");
        assert (update_count == 0)
            else report_mismatch("dac_update after plain writes", update_count, 0);

        // block write held off by a busy dac
        @(posedge clk_125MHz);
        dac_busy <= 1'b1;
        write_command(3, cur_t'(rand_bits(16)), 1'b1);
        repeat (10) @(negedge clk_125MHz);
        assert (update_count == 0)
            else report_mismatch("dac_update while dac busy", update_count, 0);
        @(posedge clk_125MHz);
        dac_busy <= 1'b0;
        wait_updates(1);
        repeat (10) @(negedge clk_125MHz);
        assert (update_count == 1)
            else report_mismatch("pulses per block write", update_count, 1);
        write_command(1, cur_t'(rand_bits(16)), 1'b0);   // plain write, dac idle
        repeat (10) @(negedge clk_125MHz);
        assert (update_count == 1)
            else report_mismatch("dac_update after plain write", update_count, 1);

        // overcurrent on channel 2, interrupted first
        write_command(2, CUR_MIDSCALE + 16'h0100, 1'b0);   // limit 768
        fb_ok     = {NUM_CHAN{CUR_MIDSCALE}};
        fb_bad    = fb_ok;
        fb_bad[2] = CUR_MIDSCALE + 16'h0301 + cur_t'(rand_bits(8));
        for (int i = 0; i < SAFETY_COUNT - 1; i++) begin
            feedback_strobe(fb_bad);
        end
        feedback_strobe(fb_ok);
        for (int i = 0; i < SAFETY_COUNT - 1; i++) begin
            feedback_strobe(fb_bad);
        end
        assert (amp_disable == '0)
            else report_mismatch("trip on interrupted run", 32'(amp_disable), 32'd0);
        feedback_strobe(fb_bad);
        assert (amp_disable == 4'b0010)
            else report_mismatch("trip on channel 2", 32'(amp_disable), 32'h2);

        // channel 4 trips below midscale
        write_command(4, CUR_MIDSCALE, 1'b0);
        fb_bad    = fb_ok;
        fb_bad[4] = CUR_MIDSCALE - 16'h0101 - cur_t'(rand_bits(8));
        for (int i = 0; i < SAFETY_COUNT; i++) begin
            feedback_strobe(fb_bad);
        end
        assert (amp_disable == 4'b1010)
            else report_mismatch("trip on channel 4", 32'(amp_disable), 32'ha);

        // feedback words as driven
        for (int i = 1; i <= NUM_CHAN; i++) begin
            read_check(make_addr(ADDR_MAIN, chan_t'(i), OFF_ADC_DATA), {16'h0, fb_bad[i]},
                       "feedback readback");
        end

        // status words and enable clears
        read_check(make_addr(ADDR_MAIN, 4'd0, OFF_BOARD_STATUS), board_status_word(),
                   "board status");
        for (int i = 1; i <= NUM_CHAN; i++) begin
            read_check(make_addr(ADDR_MAIN, chan_t'(i), OFF_MOTOR_STATUS), motor_status_word(i),
                       "motor status");
        end
        enable_write(1'b0, 4'b0010);        // mask bit of channel 2
        read_check(make_addr(ADDR_MAIN, 4'd2, OFF_MOTOR_STATUS), motor_status_word(2),
                   "motor status after clear");
        read_check(make_addr(ADDR_MAIN, 4'd0, OFF_BOARD_STATUS), board_status_word(),
                   "board status after clear");
        enable_write(1'b1, 4'b0000);        // power enable clears all
        read_check(make_addr(ADDR_MAIN, 4'd4, OFF_MOTOR_STATUS), motor_status_word(4),
                   "motor status after power enable");
        read_check(make_addr(ADDR_MAIN, 4'd0, OFF_BOARD_STATUS), board_status_word(),
                   "board status after power enable");
        feedback_strobe(fb_bad);            // run restarted by the clear

        if (update_count == 1) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_run("unexpected dac_update pulses during the run");
        end
    end

endmodule

// File: verilog.f
common/motor_pkg.sv
hdl/reg_decode.sv
cur_cmd/cur_cmd_bank.sv
safety/safety_check.sv
hdl/read_mux.sv
hdl/motor_reg_top.sv
test/tb_motor_reg.sv
